// ==== attn/sa_output_engine.sv ====
// output stage; one beat per OUT step, a cycle later, zero whenever out_valid is low
`default_nettype none

module sa_output_engine
	import sa_types_pkg::*;
	import sa_ctrl_pkg::*;
(
	input wire logic clk,
	input wire logic rst_n,
	input wire seq_ctrl_t ctrl,
	input wire mat_score_t s_mat,
	input wire mat_proj_t v_mat,
	output logic out_valid,
	output out_t out_data
);

	out_t prod [DIM];
	out_t pair [DIM/2];
	out_t quad [2];
	out_t dot;

	// ==========================================================
	// S[i][:] . V[:][n] as a balanced adder tree
	// ==========================================================

	always_comb begin
		for (int j = 0; j < DIM; j++) begin
			prod[j] = out_t'(s_mat[ctrl.row][j]) * out_t'(v_mat[j][ctrl.col]);
		end
		for (int p = 0; p < DIM/2; p++) begin
			pair[p] = prod[2*p] + prod[2*p+1];
		end
		quad[0] = pair[0] + pair[1];
		quad[1] = pair[2] + pair[3];
		dot = quad[0] + quad[1];
	end

	// ==========================================================
	// output register
	// ==========================================================

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			out_valid <= 1'b0;
			out_data <= '0;
		end else if (ctrl.phase == OUT) begin
			out_valid <= 1'b1;
			out_data <= dot;
		end else begin
			out_valid <= 1'b0;
			out_data <= '0;
		end
	end

endmodule

`default_nettype wire

// ==== attn/sa_proj_engine.sv ====
// Q, K, V projection; each step (n, k) adds one product per row into column n of every matrix
`default_nettype none

module sa_proj_engine
	import sa_types_pkg::*;
	import sa_ctrl_pkg::*;
(
	input wire logic clk,
	input wire logic rst_n,
	input wire seq_ctrl_t ctrl,
	input wire mat_elem_t x_mat,
	input wire mat_elem_t wq_mat,
	input wire mat_elem_t wk_mat,
	input wire mat_elem_t wv_mat,
	output mat_proj_t q_mat,
	output mat_proj_t k_mat,
	output mat_proj_t v_mat
);

	localparam int NMAT = 3;

	// 0 is Q, 1 is K, 2 is V
	mat_elem_t w_sel [NMAT];
	mat_proj_t p_mat [NMAT];

	assign w_sel[0] = wq_mat;
	assign w_sel[1] = wk_mat;
	assign w_sel[2] = wv_mat;

	// ==========================================================
	// 3 x 8 MAC lanes
	// ==========================================================

	for (genvar m = 0; m < NMAT; m++) begin : g_mat
		// X[i][k] * W[k][n] for each row i
		proj_t lane_prod [DIM];

		always_comb begin
			for (int i = 0; i < DIM; i++) begin
				lane_prod[i] = proj_t'(x_mat[i][ctrl.col]) *
					proj_t'(w_sel[m][ctrl.col][ctrl.row]);
			end
		end

		always_ff @(posedge clk or negedge rst_n) begin
			if (!rst_n) begin
				p_mat[m] <= '0;
			end else if (ctrl.phase == LOAD) begin
				// fresh sums for each frame
				p_mat[m] <= '0;
			end else if (ctrl.phase == PROJ) begin
				for (int i = 0; i < DIM; i++) begin
					p_mat[m][i][ctrl.row] <= p_mat[m][i][ctrl.row] + lane_prod[i];
				end
			end
		end
	end

	assign q_mat = p_mat[0];
	assign k_mat = p_mat[1];
	assign v_mat = p_mat[2];

endmodule

`default_nettype wire

// ==== attn/sa_score_engine.sv ====
// S = relu(Q*K^T / SCALE_DIV); divide truncates toward zero and negative results become zero
`default_nettype none

module sa_score_engine
	import sa_types_pkg::*;
	import sa_ctrl_pkg::*;
#(
	parameter int SCALE_DIV = 3
) (
	input wire logic clk,
	input wire logic rst_n,
	input wire seq_ctrl_t ctrl,
	input wire mat_proj_t q_mat,
	input wire mat_proj_t k_mat,
	output mat_score_t s_mat
);

	// running dot product per column j of row i
	score_t acc [DIM];
	// acc plus this step's term
	score_t lane_sum [DIM];
	score_t lane_quot [DIM];

	// ==========================================================
	// eight lanes of Q[i][k] * K[j][k]
	// ==========================================================

	always_comb begin
		for (int j = 0; j < DIM; j++) begin
			lane_sum[j] = acc[j] + score_t'(q_mat[ctrl.row][ctrl.col]) *
				score_t'(k_mat[j][ctrl.col]);
			lane_quot[j] = lane_sum[j] / score_t'(SCALE_DIV);
		end
	end

	// ==========================================================
	// accumulate, then divide and clamp on the eighth term
	// ==========================================================

	// acc is back at zero after the eighth term of every row
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			acc <= '{default: '0};
			s_mat <= '0;
		end else if (ctrl.phase == SCORE) begin
			for (int j = 0; j < DIM; j++) begin
				if (ctrl.last_col) begin
					// sign bit set means a negative quotient
					s_mat[ctrl.row][j] <= lane_quot[j][SCORE_W-1] ? score_t'(0) : lane_quot[j];
					acc[j] <= '0;
				end else begin
					acc[j] <= lane_sum[j];
				end
			end
		end
	end

endmodule

`default_nettype wire

// ==== common/sa_ctrl_pkg.sv ====
// control bundle of the phase sequencer; row and col are only meaningful inside a phase window
`default_nettype none

package sa_ctrl_pkg;

	import sa_types_pkg::*;

	// ==========================================================
	// frame phases
	// ==========================================================

	// phases run in this order, then back to idle
	typedef enum logic [2:0] {
		IDLE,
		LOAD,
		PROJ,
		SCORE,
		OUT
	} phase_e;

	// step within a phase, 0..191 at most
	typedef logic [7:0] step_t;

	// number of active rows, T = 1, 4 or 8
	typedef logic [3:0] rows_t;

	// ==========================================================
	// sequencer output
	// ==========================================================

	typedef struct packed {
		phase_e phase;
		step_t step;
		// step[5:3]
		idx_t row;
		// step[2:0]
		idx_t col;
		// eighth step of a group of eight
		logic last_col;
	} seq_ctrl_t;

endpackage

`default_nettype wire

// ==== common/sa_types_pkg.sv ====
// datapath widths for an 8x8 attention frame; sums are sized so no element can overflow
`default_nettype none

package sa_types_pkg;

	// ==========================================================
	// dimensions and widths
	// ==========================================================

	// matrix side, also the max number of rows T
	localparam int DIM = 8;

	localparam int ELEM_W = 8;
	// 8 products of 8x8 bits, plus sign growth
	localparam int PROJ_W = 19;
	// 8 products of 19x19 bits
	localparam int SCORE_W = 41;
	localparam int OUT_W = 64;
	localparam int IDX_W = 3;

	// ==========================================================
	// element types
	// ==========================================================

	// raw input and weight element
	typedef logic signed [ELEM_W-1:0] elem_t;
	// one element of Q, K or V
	typedef logic signed [PROJ_W-1:0] proj_t;
	// score accumulator and S element
	typedef logic signed [SCORE_W-1:0] score_t;
	// output beat
	typedef logic signed [OUT_W-1:0] out_t;
	// row or column within a matrix
	typedef logic [IDX_W-1:0] idx_t;

	// ==========================================================
	// matrix types, indexed [row][col]
	// ==========================================================

	typedef elem_t [DIM-1:0][DIM-1:0] mat_elem_t;
	typedef proj_t [DIM-1:0][DIM-1:0] mat_proj_t;
	typedef score_t [DIM-1:0][DIM-1:0] mat_score_t;

endpackage

`default_nettype wire

// ==== dv/sa_checker.sv ====
// DUT port monitor; assumes in_valid stays high for the whole 192-step load and T is 1, 4 or 8
`default_nettype none

module sa_checker
	import sa_types_pkg::*;
	import sa_ctrl_pkg::*;
(
	input wire logic clk,
	input wire logic rst_n,
	input wire logic in_valid,
	input wire rows_t t_rows,
	input wire elem_t in_data,
	input wire elem_t w_q,
	input wire elem_t w_k,
	input wire elem_t w_v,
	input wire logic out_valid,
	input wire out_t out_data,
	output int frames_done,
	output int err_count
);
	timeunit 1ns;
	timeprecision 1ns;

	localparam longint SCORE_DIV = 3;
	localparam int LOAD_STEPS = 192;
	// register set on the 129th edge, seen by the sampling edge after it
	localparam int OUT_DELAY = 130;

	typedef longint mat_t [DIM][DIM];

	// 0 idle, 1 load, 2 wait for first beat, 3 stream
	int state;
	int step;
	int wait_cnt;
	int beats;
	int rows_cur;
	mat_t x_cap;
	mat_t wq_cap;
	mat_t wk_cap;
	mat_t wv_cap;
	mat_t ref_res;
	// beats still owed by the current frame
	longint exp_q [$];

	initial begin
		frames_done = 0;
		err_count = 0;
	end

	// ============================================================
	// reference model
	// ============================================================

	function automatic void attention_ref(input mat_t x, input mat_t wq, input mat_t wk,
			input mat_t wv, output mat_t res);
		mat_t q;
		mat_t k;
		mat_t v;
		mat_t s;
		// projections, zero rows of X give zero rows here
		for (int i = 0; i < DIM; i++) begin
			for (int n = 0; n < DIM; n++) begin
				q[i][n] = 0;
				k[i][n] = 0;
				v[i][n] = 0;
				for (int c = 0; c < DIM; c++) begin
					q[i][n] += x[i][c] * wq[c][n];
					k[i][n] += x[i][c] * wk[c][n];
					v[i][n] += x[i][c] * wv[c][n];
				end
			end
		end
		// scores, divide truncates toward zero, then clamp at zero
		for (int i = 0; i < DIM; i++) begin
			for (int j = 0; j < DIM; j++) begin
				s[i][j] = 0;
				for (int c = 0; c < DIM; c++) begin
					s[i][j] += q[i][c] * k[j][c];
				end
				s[i][j] = s[i][j] / SCORE_DIV;
				if (s[i][j] < 0) begin
					s[i][j] = 0;
				end
			end
		end
		// S times V
		for (int i = 0; i < DIM; i++) begin
			for (int n = 0; n < DIM; n++) begin
				res[i][n] = 0;
				for (int j = 0; j < DIM; j++) begin
					res[i][n] += s[i][j] * v[j][n];
				end
			end
		end
	endfunction

	// ============================================================
	// capture and bookkeeping
	// ============================================================

	task automatic flag_error(input string msg);
		$display("[%0t] error: %s", $time, msg);
		err_count++;
	endtask

	task automatic capture_step(input int s);
		if (s < 64) begin
			wq_cap[s / 8][s % 8] = w_q;
		end else if (s < 128) begin
			// Wk streams column by column
			wk_cap[(s - 64) % 8][(s - 64) / 8] = w_k;
		end else begin
			wv_cap[(s - 128) / 8][(s - 128) % 8] = w_v;
		end
		if (s < 8 * rows_cur) begin
			x_cap[s / 8][s % 8] = in_data;
		end
	endtask

	task automatic queue_expected();
		attention_ref(x_cap, wq_cap, wk_cap, wv_cap, ref_res);
		exp_q.delete();
		// row-major, only the T live rows
		for (int i = 0; i < rows_cur; i++) begin
			for (int n = 0; n < DIM; n++) begin
				exp_q.push_back(ref_res[i][n]);
			end
		end
		beats = 0;
	endtask

	task automatic finish_frame();
		state = 0;
		frames_done++;
	endtask

	task automatic check_beat();
		longint exp;
		exp = exp_q.pop_front();
		if (out_data !== exp) begin
			$display("[FAIL] out_data frame %0d beat %0d: expected %h, got %h",
				frames_done, beats, exp, out_data);
			err_count++;
		end
		beats++;
		if (exp_q.size() == 0) begin
			finish_frame();
		end
	endtask

	// ============================================================
	// per-edge monitor
	// ============================================================

	always @(posedge clk) begin
		if (!rst_n) begin
			state = 0;
			step = 0;
			wait_cnt = 0;
			beats = 0;
		end else begin
			// idle output must read zero
			if (!out_valid && out_data !== '0) begin
				$display("[FAIL] out_data with out_valid low: expected %h, got %h",
					64'h0, out_data);
				err_count++;
			end
			case (state)
				0: begin
					if (out_valid) begin
						flag_error("output beat while no frame is pending");
					end
					if (in_valid) begin
						// frame start, T sampled here
						rows_cur = t_rows;
						x_cap = '{default: 0};
						capture_step(0);
						step = 1;
						state = 1;
					end
				end
				1: begin
					if (out_valid) begin
						flag_error("output beat during load");
					end
					capture_step(step);
					if (step == LOAD_STEPS - 1) begin
						queue_expected();
						wait_cnt = 0;
						state = 2;
					end
					step++;
				end
				2: begin
					wait_cnt++;
					if (out_valid) begin
						if (wait_cnt != OUT_DELAY) begin
							flag_error($sformatf("first beat %0d edges after load, not %0d",
								wait_cnt, OUT_DELAY));
						end
						state = 3;
						check_beat();
					end else if (wait_cnt >= OUT_DELAY) begin
						flag_error($sformatf("frame %0d produced no output beat", frames_done));
						finish_frame();
					end
				end
				default: begin
					if (out_valid) begin
						check_beat();
					end else begin
						flag_error($sformatf("frame %0d stopped after %0d of %0d beats",
							frames_done, beats, beats + exp_q.size()));
						finish_frame();
					end
				end
			endcase
		end
	end

endmodule

`default_nettype wire

// ==== dv/sa_tb.sv ====
// testbench for sa_top; runs nine frames and starts each only once the DUT is back in IDLE
`default_nettype none

module sa_tb
	import sa_types_pkg::*;
	import sa_ctrl_pkg::*;
();
	timeunit 1ns;
	timeprecision 1ns;

	localparam int CLK_PERIOD = 20;
	localparam int NUM_FRAMES = 9;
	// longest frame is 192 + 64 + 64 + 64 steps plus the output register
	localparam int FRAME_CYCLES = 400;
	localparam int MODE_RANDOM = 0;
	localparam int MODE_NEG = 1;
	localparam int MODE_EXTREME = 2;

	logic clk;
	logic rst_n;
	logic in_valid;
	rows_t t_rows;
	elem_t in_data;
	elem_t w_q;
	elem_t w_k;
	elem_t w_v;
	logic out_valid;
	out_t out_data;
	int frames_done;
	int err_count;
	int seed;
	int tests_passed;
	int tests_failed;
	// Wq of the frame in flight for the negated Wk
	elem_t wq_copy [DIM][DIM];

	always #(CLK_PERIOD / 2) clk = ~clk;

	sa_top #(
		.SCALE_DIV(3)
	) uut (
		.clk(clk),
		.rst_n(rst_n),
		.in_valid(in_valid),
		.t_rows(t_rows),
		.in_data(in_data),
		.w_q(w_q),
		.w_k(w_k),
		.w_v(w_v),
		.out_valid(out_valid),
		.out_data(out_data)
	);

	sa_checker u_chk (
		.clk(clk),
		.rst_n(rst_n),
		.in_valid(in_valid),
		.t_rows(t_rows),
		.in_data(in_data),
		.w_q(w_q),
		.w_k(w_k),
		.w_v(w_v),
		.out_valid(out_valid),
		.out_data(out_data),
		.frames_done(frames_done),
		.err_count(err_count)
	);

	// ============================================================
	// stimulus helpers
	// ============================================================

	function automatic elem_t pick_value(input int mode);
		int r;
		r = $random(seed);
		case (mode)
			// small range so negation stays in 8 bits
			MODE_NEG: return elem_t'(r % 64);
			MODE_EXTREME: return r[0] ? elem_t'(127) : elem_t'(-128);
			default: return elem_t'(r);
		endcase
	endfunction

	// one full load and a wait for the checker to close the frame
	task automatic run_frame(input int t, input int mode);
		int target;
		target = frames_done + 1;
		for (int s = 0; s < 192; s++) begin
			@(negedge clk);
			in_valid = 1'b1;
			t_rows = rows_t'(t);
			// every input is random on each step and the load windows pick what counts
			in_data = pick_value(mode);
			w_q = pick_value(mode);
			w_k = pick_value(mode);
			w_v = pick_value(mode);
			if (s < 64) begin
				wq_copy[s / 8][s % 8] = w_q;
			end
			// Wk = -Wq gives K = -Q and a negative diagonal of scores
			if (mode == MODE_NEG && s >= 64 && s < 128) begin
				w_k = -wq_copy[(s - 64) % 8][(s - 64) / 8];
			end
		end
		@(negedge clk);
		in_valid = 1'b0;
		wait (frames_done == target);
	endtask

	task automatic end_test(input string name, input int err_before);
		if (err_count == err_before) begin
			tests_passed++;
			$display("test %s: ok", name);
		end else begin
			tests_failed++;
			$display("test %s: %0d errors", name, err_count - err_before);
		end
	endtask

	// ============================================================
	// test sequence
	// ============================================================

	initial begin
		int err_before;
		int t;
		clk = 1'b0;
		rst_n = 1'b0;
		in_valid = 1'b0;
		t_rows = '0;
		in_data = '0;
		w_q = '0;
		w_k = '0;
		w_v = '0;
		seed = 74;
		tests_passed = 0;
		tests_failed = 0;
		repeat (3) @(posedge clk);
		@(negedge clk);
		rst_n = 1'b1;

		// quiet outputs before any frame
		err_before = err_count;
		repeat (20) @(negedge clk);
		end_test("1 idle after reset", err_before);

		err_before = err_count;
		run_frame(8, MODE_RANDOM);
		end_test("2 T=8 random", err_before);

		// in_data past step 8T is random junk
		err_before = err_count;
		run_frame(1, MODE_RANDOM);
		run_frame(4, MODE_RANDOM);
		end_test("3 T=1 and T=4", err_before);

		err_before = err_count;
		run_frame(8, MODE_NEG);
		end_test("4 negative scores clamp", err_before);

		err_before = err_count;
		run_frame(8, MODE_EXTREME);
		end_test("5 extreme elements", err_before);

		// several frames in a row with random T
		err_before = err_count;
		for (int f = 0; f < 4; f++) begin
			case ($unsigned($random(seed)) % 3)
				0: t = 1;
				1: t = 4;
				default: t = 8;
			endcase
			run_frame(t, MODE_RANDOM);
		end
		end_test("6 back to back frames", err_before);

		$display("tests passed: %0d, tests failed: %0d, check errors: %0d",
			tests_passed, tests_failed, err_count);
		if (tests_failed == 0 && err_count == 0) begin
			$display("sim passed");
		end else begin
			$display("sim failed");
		end
		$finish;
	end

	// ============================================================
	// watchdog
	// ============================================================

	initial begin
		#((NUM_FRAMES * FRAME_CYCLES + 100) * CLK_PERIOD);
		$display("timeout: run did not finish within %0d frame budgets", NUM_FRAMES);
		$display("sim failed");
		$finish;
	end

endmodule

`default_nettype wire

// ==== hw/sa_input_store.sv ====
// operand registers; load order is Wq row-major, Wk column-major, Wv row-major, X in the first 8T steps
`default_nettype none

module sa_input_store
	import sa_types_pkg::*;
	import sa_ctrl_pkg::*;
(
	input wire logic clk,
	input wire logic rst_n,
	input wire seq_ctrl_t ctrl,
	input wire rows_t rows,
	input wire elem_t in_data,
	input wire elem_t w_q,
	input wire elem_t w_k,
	input wire elem_t w_v,
	output mat_elem_t x_mat,
	output mat_elem_t wq_mat,
	output mat_elem_t wk_mat,
	output mat_elem_t wv_mat
);

	// first step past the live X window
	step_t x_limit;
	// step still inside the X window
	logic x_live;
	// 64-step window of the load, 0..2 are Wq, Wk, Wv
	logic [1:0] load_win;

	assign x_limit = step_t'({rows, 3'b000});
	assign x_live = ctrl.step < x_limit;
	assign load_win = ctrl.step[7:6];

	// ==========================================================
	// weight and input capture
	// ==========================================================

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			x_mat <= '0;
			wq_mat <= '0;
			wk_mat <= '0;
			wv_mat <= '0;
		end else if (ctrl.phase == LOAD) begin
			case (load_win)
				2'd0: wq_mat[ctrl.row][ctrl.col] <= w_q;
				// Wk arrives column by column
				2'd1: wk_mat[ctrl.col][ctrl.row] <= w_k;
				2'd2: wv_mat[ctrl.row][ctrl.col] <= w_v;
				default: ;
			endcase
			// X sweeps all 64 slots in the first window
			// rows at T and above get zero so old frames leave nothing behind
			if (load_win == 2'd0) begin
				x_mat[ctrl.row][ctrl.col] <= x_live ? in_data : elem_t'(0);
			end
		end
	end

endmodule

`default_nettype wire

// ==== hw/sa_sequencer.sv ====
// frame FSM; in IDLE the ctrl phase follows in_valid combinationally, so load step 0 is that cycle
`default_nettype none

module sa_sequencer
	import sa_types_pkg::*;
	import sa_ctrl_pkg::*;
(
	input wire logic clk,
	input wire logic rst_n,
	input wire logic in_valid,
	input wire rows_t t_rows,
	output seq_ctrl_t ctrl,
	output rows_t rows
);

	// last step of each fixed-length phase
	localparam step_t LOAD_LAST = step_t'(191);
	localparam step_t MAC_LAST = step_t'(63);

	phase_e phase_q;
	phase_e phase_d;
	step_t step_q;
	step_t step_d;
	rows_t rows_q;
	logic frame_start;
	logic phase_done;
	step_t out_last;

	// ==========================================================
	// frame start and row count
	// ==========================================================

	assign frame_start = (phase_q == IDLE) && in_valid;

	// T is live on the first cycle, latched afterwards
	assign rows = (phase_q == IDLE) ? t_rows : rows_q;

	// OUT runs 8T steps
	assign out_last = step_t'({rows_q, 3'b000}) - step_t'(1);

	always_comb begin
		case (phase_q)
			LOAD: phase_done = (step_q == LOAD_LAST);
			PROJ, SCORE: phase_done = (step_q == MAC_LAST);
			OUT: phase_done = (step_q == out_last);
			default: phase_done = 1'b0;
		endcase
	end

	// ==========================================================
	// next state
	// ==========================================================

	always_comb begin
		phase_d = phase_q;
		step_d = step_q + step_t'(1);
		case (phase_q)
			IDLE: begin
				// step 0 of LOAD is consumed this cycle
				phase_d = frame_start ? LOAD : IDLE;
				step_d = frame_start ? step_t'(1) : '0;
			end
			LOAD: if (phase_done) phase_d = PROJ;
			PROJ: if (phase_done) phase_d = SCORE;
			SCORE: if (phase_done) phase_d = OUT;
			OUT: if (phase_done) phase_d = IDLE;
			default: phase_d = IDLE;
		endcase
		if (phase_done) begin
			step_d = '0;
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			phase_q <= IDLE;
			step_q <= '0;
			rows_q <= '0;
		end else begin
			phase_q <= phase_d;
			step_q <= step_d;
			if (frame_start) begin
				rows_q <= t_rows;
			end
		end
	end

	// ==========================================================
	// control decode
	// ==========================================================

	always_comb begin
		ctrl.phase = frame_start ? LOAD : phase_q;
		ctrl.step = step_q;
		ctrl.row = step_q[5:3];
		ctrl.col = step_q[2:0];
		ctrl.last_col = (step_q[2:0] == 3'd7);
	end

endmodule

`default_nettype wire

// ==== hw/sa_top.sv ====
// attention top; T must be 1, 4 or 8 and in_valid must stay high for 192 cycles per frame
`default_nettype none

module sa_top
	import sa_types_pkg::*;
	import sa_ctrl_pkg::*;
#(
	parameter int SCALE_DIV = 3
) (
	input wire logic clk,
	input wire logic rst_n,
	input wire logic in_valid,
	input wire rows_t t_rows,
	input wire elem_t in_data,
	input wire elem_t w_q,
	input wire elem_t w_k,
	input wire elem_t w_v,
	output logic out_valid,
	output out_t out_data
);

	// ==========================================================
	// internal buses
	// ==========================================================

	seq_ctrl_t ctrl;
	rows_t rows;

	// loaded operands
	mat_elem_t x_mat;
	mat_elem_t wq_mat;
	mat_elem_t wk_mat;
	mat_elem_t wv_mat;

	// projections
	mat_proj_t q_mat;
	mat_proj_t k_mat;
	mat_proj_t v_mat;

	// clamped scores
	mat_score_t s_mat;

	// ==========================================================
	// control and storage
	// ==========================================================

	sa_sequencer u_seq (
		.clk(clk),
		.rst_n(rst_n),
		.in_valid(in_valid),
		.t_rows(t_rows),
		.ctrl(ctrl),
		.rows(rows)
	);

	sa_input_store u_store (
		.clk(clk),
		.rst_n(rst_n),
		.ctrl(ctrl),
		.rows(rows),
		.in_data(in_data),
		.w_q(w_q),
		.w_k(w_k),
		.w_v(w_v),
		.x_mat(x_mat),
		.wq_mat(wq_mat),
		.wk_mat(wk_mat),
		.wv_mat(wv_mat)
	);

	// ==========================================================
	// engines, data flows forward only
	// ==========================================================

	sa_proj_engine u_proj (
		.clk(clk),
		.rst_n(rst_n),
		.ctrl(ctrl),
		.x_mat(x_mat),
		.wq_mat(wq_mat),
		.wk_mat(wk_mat),
		.wv_mat(wv_mat),
		.q_mat(q_mat),
		.k_mat(k_mat),
		.v_mat(v_mat)
	);

	sa_score_engine #(
		.SCALE_DIV(SCALE_DIV)
	) u_score (
		.clk(clk),
		.rst_n(rst_n),
		.ctrl(ctrl),
		.q_mat(q_mat),
		.k_mat(k_mat),
		.s_mat(s_mat)
	);

	sa_output_engine u_out (
		.clk(clk),
		.rst_n(rst_n),
		.ctrl(ctrl),
		.s_mat(s_mat),
		.v_mat(v_mat),
		.out_valid(out_valid),
		.out_data(out_data)
	);

endmodule

`default_nettype wire

// ==== sim.f ====
common/sa_types_pkg.sv
common/sa_ctrl_pkg.sv
attn/sa_proj_engine.sv
attn/sa_score_engine.sv
attn/sa_output_engine.sv
hw/sa_sequencer.sv
hw/sa_input_store.sv
hw/sa_top.sv
dv/sa_checker.sv
dv/sa_tb.sv
